/* lsu_top.f */
+incdir+common
common/lsu_pkg.sv
cache/cache_array.sv
cache/cache_pipe.sv
store_buf/store_buf.sv
verilog/lsu_top.sv
tb/tb_lsu.sv

/* Makefile */
LOG := sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lsu -f lsu_top.f
	./obj_dir/Vtb_lsu | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* tb/tb_lsu.sv */
// testbench driving fills, loads, stores and commits into the load/store unit against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module tb_lsu;

  localparam int N_RAND   = 400;
  localparam int N_DIRECT = 100; // directed operations rounded up
  localparam int N_SETS   = 1 << `LSU_SET_W;
  localparam int TW       = lsu_pkg::TAG_W;

  logic               clk;
  logic               rst_n;
  logic               req_valid_i;
  lsu_pkg::lsu_req_t  req_i;
  logic               commit_i;
  logic               fill_valid_i;
  lsu_pkg::fill_t     fill_i;
  logic               req_ready_o;
  logic               resp_valid_o;
  lsu_pkg::lsu_resp_t resp_o;

  logic               ref_vld  [`LSU_WAYS][N_SETS];
  logic [TW-1:0]      ref_tag  [`LSU_WAYS][N_SETS];
  lsu_pkg::line_t     ref_line [`LSU_WAYS][N_SETS];
  lsu_pkg::sb_entry_t ref_sb [$]; // oldest first
  lsu_pkg::lsu_resp_t exp_q [$];

  integer seed = 32'ha23f;
  int     n_checks = 0;
  int     n_mism = 0;
  int     n_other = 0;

  lsu_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .commit_i     (commit_i),
    .fill_valid_i (fill_valid_i),
    .fill_i       (fill_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [TW-1:0] tag_of(input int t);
    return TW'(32'h5a3 + t);
  endfunction

  function automatic lsu_pkg::lsu_req_t mk_req(input int t, input logic [7:0] s,
                                               input logic [3:0] off, input logic [1:0] sz,
                                               input logic sgn, input logic wr,
                                               input logic [31:0] d);
    lsu_pkg::lsu_req_t r;
    r         = '0;
    r.paddr   = {tag_of(t), s, off};
    r.msize   = sz;
    r.msigned = sgn;
    r.wreq    = wr;
    case (sz)
      lsu_pkg::MSIZE_BYTE: r.strb = 4'b0001 << off[1:0];
      lsu_pkg::MSIZE_HALF: r.strb = 4'b0011 << off[1:0];
      default:             r.strb = 4'b1111;
    endcase
    r.wdata   = d << (8 * off[1:0]); // into byte lanes
    return r;
  endfunction

  function automatic logic [3:0] way_hits(input logic [31:0] a);
    logic [3:0] h;
    h = '0;
    for (int w = 0; w < `LSU_WAYS; w++) begin
      h[w] = ref_vld[w][a[11:4]] && (ref_tag[w][a[11:4]] == a[31:12]);
    end
    return h;
  endfunction

  // expected response from the array word and pending stores oldest to newest, then extract
  function automatic lsu_pkg::lsu_resp_t ref_resp(input lsu_pkg::lsu_req_t r);
    lsu_pkg::lsu_resp_t res;
    logic [3:0]         h;
    logic [31:0]        word;
    logic [31:0]        sh;
    res      = '0;
    word     = '0;
    h        = way_hits(r.paddr);
    res.wreq = r.wreq;
    res.ale  = (r.msize == lsu_pkg::MSIZE_HALF) ? r.paddr[0] :
               (r.msize == lsu_pkg::MSIZE_WORD) ? (r.paddr[1:0] != 2'b00) : 1'b0;
    for (int w = 0; w < `LSU_WAYS; w++) begin
      if (h[w]) begin
        word = ref_line[w][r.paddr[11:4]][r.paddr[3:2]];
      end
    end
    foreach (ref_sb[i]) begin
      for (int b = 0; b < 4; b++) begin
        if (ref_sb[i].paddr[31:2] == r.paddr[31:2] && ref_sb[i].strb[b]) begin
          word[8*b +: 8] = ref_sb[i].wdata[8*b +: 8];
        end
      end
    end
    sh = word >> (8 * r.paddr[1:0]);
    case (r.msize)
      lsu_pkg::MSIZE_BYTE: sh = {r.msigned ? {24{sh[7]}} : 24'h0, sh[7:0]};
      lsu_pkg::MSIZE_HALF: sh = {r.msigned ? {16{sh[15]}} : 16'h0, sh[15:0]};
      default:             sh = sh;
    endcase
    res.hit = (h != 4'h0) && !res.ale;
    if (res.hit && !r.wreq) begin
      res.rdata = sh;
    end
    return res;
  endfunction

  task automatic issue(input lsu_pkg::lsu_req_t r);
    lsu_pkg::lsu_resp_t x;
    lsu_pkg::sb_entry_t e;
    x = ref_resp(r);
    exp_q.push_back(x);
    if (r.wreq && !x.ale) begin
      e.paddr   = r.paddr;
      e.hit_way = way_hits(r.paddr); // recorded at entry
      e.strb    = r.strb;
      e.wdata   = r.wdata;
      ref_sb.push_back(e);
    end
    req_valid_i = 1'b1;
    req_i       = r;
    while (!req_ready_o) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic commit_one();
    lsu_pkg::sb_entry_t e;
    commit_i = 1'b1;
    @(posedge clk);
    #1;
    commit_i = 1'b0;
    if (ref_sb.size() > 0) begin
      e = ref_sb.pop_front();
      for (int w = 0; w < `LSU_WAYS; w++) begin
        for (int b = 0; b < 4; b++) begin
          if (e.hit_way[w] && e.strb[b]) begin // missed stores vanish
            ref_line[w][e.paddr[11:4]][e.paddr[3:2]][8*b +: 8] = e.wdata[8*b +: 8];
          end
        end
      end
    end
  endtask

  task automatic drain_all();
    wait_idle();
    while (ref_sb.size() > 0) begin
      commit_one();
    end
  endtask

  task automatic fill_line(input logic [7:0] s, input int t);
    lsu_pkg::fill_t f;
    wait_idle();
    repeat (2) @(posedge clk); // let any drain write finish
    #1;
    f.set       = s;
    f.way       = 2'(t % 4);
    f.tag.valid = 1'b1;
    f.tag.tag   = tag_of(t);
    for (int k = 0; k < 4; k++) begin
      f.data[k] = $random(seed);
    end
    fill_valid_i = 1'b1;
    fill_i       = f;
    @(posedge clk);
    #1;
    fill_valid_i = 1'b0;
    ref_vld[f.way][s]  = 1'b1;
    ref_tag[f.way][s]  = f.tag.tag;
    ref_line[f.way][s] = f.data;
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v == exp_v) else begin
      n_mism++;
      $display("MISMATCH time %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  // responses are stable at the falling edge
  always @(negedge clk) begin
    lsu_pkg::lsu_resp_t x;
    if (rst_n && resp_valid_o) begin
      assert (exp_q.size() != 0) else begin
        n_other++;
        $display("time %0t: response arrived with no request outstanding", $time);
      end
      if (exp_q.size() != 0) begin
        x = exp_q.pop_front();
        n_checks++;
        check_field("resp_o.rdata", x.rdata, resp_o.rdata);
        check_field("resp_o.hit", 32'(x.hit), 32'(resp_o.hit));
        check_field("resp_o.ale", 32'(x.ale), 32'(resp_o.ale));
        check_field("resp_o.wreq", 32'(x.wreq), 32'(resp_o.wreq));
        check_field("resp_o.rsvd", 32'(x.rsvd), 32'(resp_o.rsvd));
      end
    end
  end

  initial begin
    #(20 * (N_RAND + N_DIRECT) * 10);
    $display("timeout: %0d responses never arrived", exp_q.size());
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mism, n_other + 1);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [7:0]  s;
    logic [1:0]  sz;
    int          t;
    for (int w = 0; w < `LSU_WAYS; w++) begin
      for (int k = 0; k < N_SETS; k++) begin
        ref_vld[w][k] = 1'b0;
      end
    end
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    commit_i     = 1'b0;
    fill_valid_i = 1'b0;
    fill_i       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // loads of every size after fills and loads that miss
    fill_line(8'h10, 0);
    fill_line(8'h10, 1);
    for (int k = 0; k < 16; k++) begin
      issue(mk_req(k % 2, 8'h10, 4'(k), lsu_pkg::MSIZE_BYTE, k[1], 1'b0, 32'h0));
    end
    for (int k = 0; k < 8; k++) begin
      issue(mk_req(k % 2, 8'h10, 4'(2 * k), lsu_pkg::MSIZE_HALF, k[0], 1'b0, 32'h0));
    end
    for (int k = 0; k < 4; k++) begin
      issue(mk_req(k % 2, 8'h10, 4'(4 * k), lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    end
    issue(mk_req(2, 8'h10, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    issue(mk_req(0, 8'h11, 4'h0, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));

    // misaligned accesses
    issue(mk_req(0, 8'h10, 4'h1, lsu_pkg::MSIZE_HALF, 1'b1, 1'b0, 32'h0));
    issue(mk_req(0, 8'h10, 4'h6, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    issue(mk_req(0, 8'h10, 4'h9, lsu_pkg::MSIZE_WORD, 1'b0, 1'b1, 32'hdeadbeef));
    issue(mk_req(0, 8'h10, 4'hb, lsu_pkg::MSIZE_HALF, 1'b0, 1'b1, 32'hbeef));
    issue(mk_req(0, 8'h10, 4'h8, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    drain_all();
    commit_one();
    issue(mk_req(0, 8'h10, 4'h8, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));

    // store to load forwarding with partial strobes
    fill_line(8'h20, 3);
    issue(mk_req(3, 8'h20, 4'h5, lsu_pkg::MSIZE_BYTE, 1'b0, 1'b1, 32'h11));
    issue(mk_req(3, 8'h20, 4'h6, lsu_pkg::MSIZE_HALF, 1'b0, 1'b1, 32'h2233));
    issue(mk_req(3, 8'h20, 4'h6, lsu_pkg::MSIZE_BYTE, 1'b0, 1'b1, 32'h94));
    issue(mk_req(3, 8'h20, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    issue(mk_req(3, 8'h20, 4'h6, lsu_pkg::MSIZE_HALF, 1'b1, 1'b0, 32'h0));
    issue(mk_req(3, 8'h20, 4'h6, lsu_pkg::MSIZE_BYTE, 1'b1, 1'b0, 32'h0));
    issue(mk_req(3, 8'h20, 4'h5, lsu_pkg::MSIZE_BYTE, 1'b0, 1'b0, 32'h0));

    // commit drain then a missed store
    drain_all();
    issue(mk_req(3, 8'h20, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    issue(mk_req(3, 8'h20, 4'h6, lsu_pkg::MSIZE_HALF, 1'b1, 1'b0, 32'h0));
    issue(mk_req(4, 8'h10, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b1, 32'h12345678));
    drain_all();
    issue(mk_req(0, 8'h10, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    issue(mk_req(4, 8'h10, 4'h4, lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));

    // five stores without commit
    for (int k = 0; k < 4; k++) begin
      issue(mk_req(0, 8'h10, 4'(4 * k), lsu_pkg::MSIZE_WORD, 1'b0, 1'b1, $random(seed)));
    end
    issue(mk_req(0, 8'h10, 4'h1, lsu_pkg::MSIZE_BYTE, 1'b0, 1'b1, 32'h5c));
    @(posedge clk);
    #1;
    assert (!req_ready_o) else begin
      n_other++;
      $display("time %0t: req_ready_o stayed high with four stores buffered", $time);
    end
    commit_one();
    wait_idle();
    commit_one();
    for (int k = 0; k < 4; k++) begin
      issue(mk_req(0, 8'h10, 4'(4 * k), lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    end
    issue(mk_req(0, 8'h10, 4'h1, lsu_pkg::MSIZE_BYTE, 1'b1, 1'b0, 32'h0));
    drain_all();
    for (int k = 0; k < 4; k++) begin
      issue(mk_req(0, 8'h10, 4'(4 * k), lsu_pkg::MSIZE_WORD, 1'b0, 1'b0, 32'h0));
    end

    // random mix on four sets and six tags
    for (int n = 0; n < N_RAND; n++) begin
      rnd = $random(seed);
      s   = 8'h40 + {6'h0, rnd[5:4]};
      t   = int'(rnd[8:6]) % 6;
      sz  = (rnd[17:16] == 2'd3) ? lsu_pkg::MSIZE_WORD : rnd[17:16];
      if (rnd[3:0] == 4'd0) begin
        fill_line(s, t);
      end else if (rnd[3:0] < 4'd3) begin
        wait_idle();
        commit_one();
      end else begin
        if (ref_sb.size() == `LSU_SB_DEPTH) begin
          wait_idle(); // a full buffer stalls the whole pipe
          commit_one();
        end
        issue(mk_req(t, s, rnd[15:12], sz, rnd[18], rnd[3:0] > 4'd9, $random(seed)));
      end
    end
    drain_all();
    repeat (4) @(posedge clk);

    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mism, n_other);
    if (n_mism == 0 && n_other == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// load/store unit top joining the request pipe, the cache array and the store buffer
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               req_valid_i,
  input  wire lsu_pkg::lsu_req_t  req_i,
  input  wire logic               commit_i,
  input  wire logic               fill_valid_i,
  input  wire lsu_pkg::fill_t     fill_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output lsu_pkg::lsu_resp_t      resp_o
);

  logic [`LSU_SET_W-1:0]                  rd_set;
  lsu_pkg::tag_t [`LSU_WAYS-1:0]          rd_tags;
  lsu_pkg::line_t [`LSU_WAYS-1:0]         rd_lines;
  lsu_pkg::arr_wr_t                       applied_wr;
  logic                                   applied_fill_valid;
  lsu_pkg::fill_t                         applied_fill;
  logic                                   drain_ready;
  lsu_pkg::arr_wr_t                       drain_wr;
  logic                                   sb_push;
  lsu_pkg::sb_entry_t                     sb_push_entry;
  logic [`LSU_SB_DEPTH-1:0]               sb_valid;
  lsu_pkg::sb_entry_t [`LSU_SB_DEPTH-1:0] sb_entries;
  logic                                   sb_full;

  cache_pipe u_cache_pipe (
    .clk                  (clk),
    .rst_n                (rst_n),
    .req_valid_i          (req_valid_i),
    .req_i                (req_i),
    .rd_tags_i            (rd_tags),
    .rd_lines_i           (rd_lines),
    .applied_wr_i         (applied_wr),
    .applied_fill_valid_i (applied_fill_valid),
    .applied_fill_i       (applied_fill),
    .sb_valid_i           (sb_valid),
    .sb_entries_i         (sb_entries),
    .sb_full_i            (sb_full),
    .req_ready_o          (req_ready_o),
    .rd_set_o             (rd_set),
    .sb_push_o            (sb_push),
    .sb_push_entry_o      (sb_push_entry),
    .resp_valid_o         (resp_valid_o),
    .resp_o               (resp_o)
  );

  cache_array u_cache_array (
    .clk                  (clk),
    .rst_n                (rst_n),
    .rd_set_i             (rd_set),
    .fill_valid_i         (fill_valid_i),
    .fill_i               (fill_i),
    .drain_wr_i           (drain_wr),
    .rd_tags_o            (rd_tags),
    .rd_lines_o           (rd_lines),
    .applied_wr_o         (applied_wr),
    .applied_fill_valid_o (applied_fill_valid),
    .applied_fill_o       (applied_fill),
    .drain_ready_o        (drain_ready)
  );

  store_buf u_store_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (sb_push),
    .push_entry_i  (sb_push_entry),
    .commit_i      (commit_i),
    .drain_ready_i (drain_ready),
    .valid_o       (sb_valid),
    .entries_o     (sb_entries),
    .full_o        (sb_full),
    .drain_wr_o    (drain_wr)
  );

endmodule

`default_nettype wire

/* store_buf/store_buf.sv */
// ordered store queue with age-ordered forwarding view and commit-driven drain
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module store_buf (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                push_i,
  input  wire lsu_pkg::sb_entry_t  push_entry_i,
  input  wire logic                commit_i,
  input  wire logic                drain_ready_i,
  output logic [`LSU_SB_DEPTH-1:0] valid_o,
  output lsu_pkg::sb_entry_t [`LSU_SB_DEPTH-1:0] entries_o,
  output logic                     full_o,
  output lsu_pkg::arr_wr_t         drain_wr_o
);

  localparam int DEPTH = `LSU_SB_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  lsu_pkg::sb_entry_t mem [DEPTH];
  lsu_pkg::sb_entry_t drain_q;
  logic [PTR_W-1:0]   head_q;
  logic [CNT_W-1:0]   count_q;
  logic [CNT_W-1:0]   pend_q;  // committed, not yet popped
  logic [CNT_W-1:0]   occ;
  logic               drain_vld_q;
  logic               drain_free;
  logic               commit_ok;
  logic               do_pop;

  // the drain register still counts as a slot until the array takes it
  assign occ        = count_q + CNT_W'(drain_vld_q);
  assign full_o     = (occ == CNT_W'(DEPTH));
  assign drain_free = !drain_vld_q || drain_ready_i;
  assign commit_ok  = commit_i && (count_q > pend_q); // ignored when nothing to commit
  assign do_pop     = (commit_ok || pend_q != '0) && drain_free;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[head_q + count_q[PTR_W-1:0]] <= push_entry_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q      <= '0;
      count_q     <= '0;
      pend_q      <= '0;
      drain_vld_q <= 1'b0;
    end else begin
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
      pend_q  <= pend_q + CNT_W'(commit_ok) - CNT_W'(do_pop);
      if (do_pop) begin
        head_q      <= head_q + 1'b1;
        drain_vld_q <= |mem[head_q].hit_way; // missed store dropped here
      end else if (drain_ready_i) begin
        drain_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) begin
      drain_q <= mem[head_q];
    end
  end

  // slot 0 is the oldest, drain register first
  always_comb begin
    logic [PTR_W-1:0] idx;
    for (int i = 0; i < DEPTH; i++) begin
      idx          = head_q + PTR_W'(i) - PTR_W'(drain_vld_q);
      valid_o[i]   = CNT_W'(i) < occ;
      entries_o[i] = (i == 0 && drain_vld_q) ? drain_q : mem[idx];
    end
  end

  always_comb begin
    drain_wr_o       = '0;
    drain_wr_o.valid = drain_vld_q;
    drain_wr_o.set   = drain_q.paddr[4 +: `LSU_SET_W];
    drain_wr_o.word  = drain_q.paddr[3:2];
    drain_wr_o.strb  = drain_q.strb;
    drain_wr_o.wdata = drain_q.wdata;
    for (int w = 0; w < `LSU_WAYS; w++) begin
      if (drain_q.hit_way[w]) begin
        drain_wr_o.way = 2'(w); // one-hot to index
      end
    end
  end

endmodule

`default_nettype wire

/* cache/cache_pipe.sv */
// two-stage load/store request pipe: tag compare, forwarding, store merge and response
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module cache_pipe (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      req_valid_i,
  input  wire lsu_pkg::lsu_req_t         req_i,
  input  wire lsu_pkg::tag_t [`LSU_WAYS-1:0]  rd_tags_i,
  input  wire lsu_pkg::line_t [`LSU_WAYS-1:0] rd_lines_i,
  input  wire lsu_pkg::arr_wr_t          applied_wr_i,
  input  wire logic                      applied_fill_valid_i,
  input  wire lsu_pkg::fill_t            applied_fill_i,
  input  wire logic [`LSU_SB_DEPTH-1:0]  sb_valid_i,
  input  wire lsu_pkg::sb_entry_t [`LSU_SB_DEPTH-1:0] sb_entries_i,
  input  wire logic                      sb_full_i,
  output logic                           req_ready_o,
  output logic [`LSU_SET_W-1:0]          rd_set_o,
  output logic                           sb_push_o,
  output lsu_pkg::sb_entry_t             sb_push_entry_o,
  output logic                           resp_valid_o,
  output lsu_pkg::lsu_resp_t             resp_o
);

  localparam int SET_LSB = 4;
  localparam int TAG_W   = lsu_pkg::TAG_W;

  logic                           hold;
  logic                           m0_valid_q;
  logic                           m1_valid_q;
  lsu_pkg::lsu_req_t              m0_req_q;
  lsu_pkg::lsu_req_t              m1_req_q;
  logic [`LSU_SET_W-1:0]          m1_set;
  lsu_pkg::tag_t [`LSU_WAYS-1:0]  m1_tags;
  lsu_pkg::line_t [`LSU_WAYS-1:0] m1_lines;
  logic [`LSU_WAYS-1:0]           m1_hit;
  logic                           m1_ale;
  logic [31:0]                    m1_word;
  logic [31:0]                    m1_shift;
  logic [31:0]                    m1_rdata;

  assign hold        = sb_full_i; // only back-pressure source
  assign req_ready_o = !hold;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m0_valid_q <= 1'b0;
      m1_valid_q <= 1'b0;
    end else if (!hold) begin
      m0_valid_q <= req_valid_i;
      m1_valid_q <= m0_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      m0_req_q <= req_i;
      m1_req_q <= m0_req_q;
    end
  end

  // a held M1 request keeps re-reading its own set
  assign m1_set   = m1_req_q.paddr[SET_LSB +: `LSU_SET_W];
  assign rd_set_o = hold ? m1_set : m0_req_q.paddr[SET_LSB +: `LSU_SET_W];

  // patch in writes that landed on the edge of the read
  always_comb begin
    m1_tags  = rd_tags_i;
    m1_lines = rd_lines_i;
    if (applied_fill_valid_i && applied_fill_i.set == m1_set) begin
      m1_tags[applied_fill_i.way]  = applied_fill_i.tag;
      m1_lines[applied_fill_i.way] = applied_fill_i.data;
    end
    if (applied_wr_i.valid && applied_wr_i.set == m1_set) begin
      for (int b = 0; b < 4; b++) begin
        if (applied_wr_i.strb[b]) begin
          m1_lines[applied_wr_i.way][applied_wr_i.word][b*8 +: 8] =
            applied_wr_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    for (int w = 0; w < `LSU_WAYS; w++) begin
      m1_hit[w] = m1_tags[w].valid && (m1_tags[w].tag == m1_req_q.paddr[31 -: TAG_W]);
    end
  end

  always_comb begin
    case (m1_req_q.msize)
      lsu_pkg::MSIZE_BYTE: m1_ale = 1'b0;
      lsu_pkg::MSIZE_HALF: m1_ale = m1_req_q.paddr[0];
      default:             m1_ale = |m1_req_q.paddr[1:0];
    endcase
  end

  // hit word, then pending stores oldest to newest so the newest byte wins
  always_comb begin
    m1_word = '0;
    for (int w = 0; w < `LSU_WAYS; w++) begin
      if (m1_hit[w]) begin
        m1_word = m1_word | m1_lines[w][m1_req_q.paddr[3:2]];
      end
    end
    for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
      if (sb_valid_i[i] && sb_entries_i[i].paddr[31:2] == m1_req_q.paddr[31:2]) begin
        for (int b = 0; b < 4; b++) begin
          if (sb_entries_i[i].strb[b]) begin
            m1_word[b*8 +: 8] = sb_entries_i[i].wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  assign m1_shift = m1_word >> {m1_req_q.paddr[1:0], 3'b000};

  always_comb begin
    case (m1_req_q.msize)
      lsu_pkg::MSIZE_BYTE: m1_rdata = {{24{m1_req_q.msigned && m1_shift[7]}}, m1_shift[7:0]};
      lsu_pkg::MSIZE_HALF: m1_rdata = {{16{m1_req_q.msigned && m1_shift[15]}}, m1_shift[15:0]};
      default:             m1_rdata = m1_shift;
    endcase
  end

  assign sb_push_o = m1_valid_q && m1_req_q.wreq && !m1_ale && !hold;

  always_comb begin
    sb_push_entry_o.paddr   = m1_req_q.paddr;
    sb_push_entry_o.hit_way = m1_hit;
    sb_push_entry_o.strb    = m1_req_q.strb;
    sb_push_entry_o.wdata   = m1_req_q.wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= m1_valid_q && !hold; // one strobe per request
    end
  end

  always_ff @(posedge clk) begin
    resp_o.rdata <= (|m1_hit && !m1_ale && !m1_req_q.wreq) ? m1_rdata : '0;
    resp_o.hit   <= |m1_hit && !m1_ale;
    resp_o.ale   <= m1_ale;
    resp_o.wreq  <= m1_req_q.wreq;
    resp_o.rsvd  <= '0;
  end

endmodule

`default_nettype wire

/* cache/cache_array.sv */
// set-associative tag and data storage with fill/drain write port and write report
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module cache_array (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [`LSU_SET_W-1:0]  rd_set_i,
  input  wire logic                   fill_valid_i,
  input  wire lsu_pkg::fill_t         fill_i,
  input  wire lsu_pkg::arr_wr_t       drain_wr_i,
  output lsu_pkg::tag_t [`LSU_WAYS-1:0]  rd_tags_o,
  output lsu_pkg::line_t [`LSU_WAYS-1:0] rd_lines_o,
  output lsu_pkg::arr_wr_t            applied_wr_o,
  output logic                        applied_fill_valid_o,
  output lsu_pkg::fill_t              applied_fill_o,
  output logic                        drain_ready_o
);

  localparam int SETS = 1 << `LSU_SET_W;

  logic [SETS-1:0][`LSU_WAYS-1:0] valid_q;
  logic [lsu_pkg::TAG_W-1:0]      tag_mem [`LSU_WAYS][SETS];
  lsu_pkg::line_t                 line_mem [`LSU_WAYS][SETS];
  logic                           drain_we;
  logic                           applied_wr_vld_q;
  lsu_pkg::arr_wr_t               applied_wr_q;

  assign drain_ready_o = !fill_valid_i; // fill owns the port
  assign drain_we      = drain_wr_i.valid && !fill_valid_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_i.set][fill_i.way] <= fill_i.tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid_i) begin
      tag_mem[fill_i.way][fill_i.set]  <= fill_i.tag.tag;
      line_mem[fill_i.way][fill_i.set] <= fill_i.data;
    end else if (drain_we) begin
      for (int b = 0; b < 4; b++) begin
        if (drain_wr_i.strb[b]) begin
          line_mem[drain_wr_i.way][drain_wr_i.set][drain_wr_i.word][b*8 +: 8] <=
            drain_wr_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read sees storage before this edge's write
  always_ff @(posedge clk) begin
    for (int w = 0; w < `LSU_WAYS; w++) begin
      rd_tags_o[w].valid <= valid_q[rd_set_i][w];
      rd_tags_o[w].tag   <= tag_mem[w][rd_set_i];
      rd_lines_o[w]      <= line_mem[w][rd_set_i];
    end
  end

  // report lines up with the storage update
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      applied_wr_vld_q     <= 1'b0;
      applied_fill_valid_o <= 1'b0;
    end else begin
      applied_wr_vld_q     <= drain_we;
      applied_fill_valid_o <= fill_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    applied_wr_q   <= drain_wr_i;
    applied_fill_o <= fill_i;
  end

  always_comb begin
    applied_wr_o       = applied_wr_q;
    applied_wr_o.valid = applied_wr_vld_q;
  end

endmodule

`default_nettype wire

/* common/lsu_pkg.sv */
// shared request, response, array and store buffer types of the load/store unit
`default_nettype none
`include "lsu_defs.svh"

package lsu_pkg;

  localparam int TAG_W = 32 - `LSU_SET_W - 4; // paddr[31:12]

  localparam logic [1:0] MSIZE_BYTE = 2'd0;
  localparam logic [1:0] MSIZE_HALF = 2'd1;
  localparam logic [1:0] MSIZE_WORD = 2'd2;

  typedef struct packed {
    logic [31:0] paddr;
    logic [1:0]  msize;   // see MSIZE_*
    logic        msigned;
    logic        wreq;
    logic [3:0]  strb;
    logic [31:0] wdata;   // already in byte lanes
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        hit;
    logic        ale;     // misaligned access
    logic        wreq;
    logic [1:0]  rsvd;
  } lsu_resp_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_t;

  typedef logic [3:0][31:0] line_t;

  typedef struct packed {
    logic [`LSU_SET_W-1:0] set;
    logic [1:0]            way;
    tag_t                  tag;
    line_t                 data;
  } fill_t;

  typedef struct packed {
    logic [31:0]          paddr;
    logic [`LSU_WAYS-1:0] hit_way; // one-hot, zero on miss
    logic [3:0]           strb;
    logic [31:0]          wdata;
  } sb_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_SET_W-1:0] set;
    logic [1:0]            way;
    logic [1:0]            word;
    logic [3:0]            strb;
    logic [31:0]           wdata;
    logic                  tag_we;
  } arr_wr_t;

endpackage

`default_nettype wire

/* common/lsu_defs.svh */
// load/store unit geometry shared by the package and the RTL blocks
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// set index taken from paddr[11:4], 16-byte lines
`define LSU_SET_W 8

// associativity of the tag and data arrays
`define LSU_WAYS 4

// buffered stores waiting for commit
`define LSU_SB_DEPTH 4

`endif
